// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= spiMasterTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: project.f
src/spiBusPkg.sv
src/sdAccessPkg.sv
src/spiBitTimer.sv
src/spiByteShifter.sv
src/spiCtrl.sv
src/sdSequencer.sv
src/spiMaster.sv
verification/sdCardModel.sv
verification/spiMasterTb.sv

// File: src/sdAccessPkg.sv
// SD access package: transfer type and block request enums, block address, command bytes and tokens
package sdAccessPkg;

  // Host transfer selection
  typedef enum logic [1:0] {
    DIRECT_ACCESS     = 2'd0,
    INIT_SD           = 2'd1,
    RW_READ_SD_BLOCK  = 2'd2,
    RW_WRITE_SD_BLOCK = 2'd3
  } transTypeT;

  // Request from the dispatcher to the byte sequencer
  typedef enum logic [1:0] {
    NO_BLOCK_REQ   = 2'd0,
    READ_SD_BLOCK  = 2'd1,
    WRITE_SD_BLOCK = 2'd2
  } blockReqT;

  // Block address as sent in the command argument
  typedef logic [31:0] blockAddrT;

  ////////////////////
  // Command bytes and tokens
  ////////////////////
  localparam logic [7:0] CMD0_BYTE   = 8'h40;
  localparam logic [7:0] CMD17_BYTE  = 8'h51;
  localparam logic [7:0] CMD24_BYTE  = 8'h58;
  localparam logic [7:0] CMD0_CRC    = 8'h95;
  localparam logic [7:0] DUMMY_BYTE  = 8'hFF;
  localparam logic [7:0] START_TOKEN = 8'hFE;

  // Clock-only bytes sent before CMD0, chip select high
  localparam int INIT_DUMMY_BYTES = 10;

endpackage

// File: src/sdSequencer.sv
// SD byte sequencer module: init dummy run, command frame, write token, block data and CRC bytes
module sdSequencer
  import spiBusPkg::*;
  import sdAccessPkg::*;
#(
  parameter int BLOCK_LEN = 16
)
(
  input  logic      clk,
  input  logic      rst,
  input  logic      sdInitReq,
  input  blockReqT  blockReq,
  input  blockAddrT blockAddr,
  input  byteT      writeData,
  input  logic      byteDone,
  input  byteT      rxData,
  output logic      seqByteStart,
  output byteT      seqTxByte,
  output logic      seqCsN,
  output logic      sdInitRdy,
  output logic      blockRdy,
  output logic      writeDataStrobe,
  output byteT      readData,
  output logic      readDataValid
);

  // Wide enough for the dummy run, the command frame and a block
  localparam int CNT_W   = $clog2(BLOCK_LEN + INIT_DUMMY_BYTES);
  localparam int CMD_LEN = 6;

  typedef enum logic [2:0] {PH_IDLE, PH_DUMMY, PH_CMD, PH_TOKEN, PH_DATA, PH_CRC, PH_DONE} phaseT;

  phaseT            phase;
  logic [CNT_W-1:0] byteCnt;
  logic             isInit;
  logic             isWrite;
  // Shifter latches rxData one cycle after byteDone
  logic             readPending;
  // Command argument, shifted out MSB first
  blockAddrT        addrReg;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      phase <= PH_IDLE;
      byteCnt <= '0;
      isInit <= 1'b0;
      isWrite <= 1'b0;
      readPending <= 1'b0;
      seqByteStart <= 1'b0;
      seqCsN <= CS_INACTIVE;
      sdInitRdy <= 1'b0;
      blockRdy <= 1'b0;
      writeDataStrobe <= 1'b0;
      readDataValid <= 1'b0;
    end
    else
    begin
      seqByteStart <= 1'b0;
      sdInitRdy <= 1'b0;
      blockRdy <= 1'b0;
      writeDataStrobe <= 1'b0;
      readDataValid <= 1'b0;
      readPending <= 1'b0;
      if (readPending)
      begin
        readData <= rxData;
        readDataValid <= 1'b1;
      end
      case (phase)
        PH_IDLE:
          if (sdInitReq)
          begin
            // Card needs clocks with chip select high before CMD0
            phase <= PH_DUMMY;
            byteCnt <= '0;
            isInit <= 1'b1;
            seqByteStart <= 1'b1;
            seqTxByte <= DUMMY_BYTE;
          end
          else if (blockReq != NO_BLOCK_REQ)
          begin
            phase <= PH_CMD;
            byteCnt <= '0;
            isInit <= 1'b0;
            isWrite <= (blockReq == WRITE_SD_BLOCK);
            addrReg <= blockAddr;
            seqCsN <= CS_ACTIVE;
            seqByteStart <= 1'b1;
            seqTxByte <= (blockReq == WRITE_SD_BLOCK) ? CMD24_BYTE : CMD17_BYTE;
          end
        PH_DUMMY:
          if (byteDone)
          begin
            seqByteStart <= 1'b1;
            if (byteCnt == CNT_W'(INIT_DUMMY_BYTES - 1))
            begin
              phase <= PH_CMD;
              byteCnt <= '0;
              addrReg <= '0;
              seqCsN <= CS_ACTIVE;
              seqTxByte <= CMD0_BYTE;
            end
            else
            begin
              byteCnt <= byteCnt + 1'b1;
              seqTxByte <= DUMMY_BYTE;
            end
          end
        // Command frame holds the command at index 0, argument at 1 to 4 and CRC at 5
        PH_CMD:
          if (byteDone)
          begin
            if (byteCnt == CNT_W'(CMD_LEN - 1))
            begin
              byteCnt <= '0;
              if (isInit)
                phase <= PH_DONE;
              else
              begin
                phase <= isWrite ? PH_TOKEN : PH_DATA;
                seqByteStart <= 1'b1;
                seqTxByte <= isWrite ? START_TOKEN : DUMMY_BYTE;
              end
            end
            else
            begin
              byteCnt <= byteCnt + 1'b1;
              seqByteStart <= 1'b1;
              if (byteCnt == CNT_W'(CMD_LEN - 2))
                seqTxByte <= isInit ? CMD0_CRC : DUMMY_BYTE;
              else
              begin
                seqTxByte <= addrReg[31:24];
                addrReg <= {addrReg[23:0], 8'h00};
              end
            end
          end
        PH_TOKEN:
          if (byteDone)
          begin
            phase <= PH_DATA;
            byteCnt <= '0;
            seqByteStart <= 1'b1;
            seqTxByte <= writeData;
            writeDataStrobe <= 1'b1;
          end
        PH_DATA:
          if (byteDone)
          begin
            readPending <= !isWrite;
            if (byteCnt == CNT_W'(BLOCK_LEN - 1))
            begin
              byteCnt <= '0;
              phase <= isWrite ? PH_CRC : PH_DONE;
              seqByteStart <= isWrite;
              seqTxByte <= DUMMY_BYTE;
            end
            else
            begin
              // Reads clock out fill bytes, writes take the next host byte
              byteCnt <= byteCnt + 1'b1;
              seqByteStart <= 1'b1;
              seqTxByte <= isWrite ? writeData : DUMMY_BYTE;
              writeDataStrobe <= isWrite;
            end
          end
        // Two dummy CRC bytes
        PH_CRC:
          if (byteDone)
          begin
            if (byteCnt == CNT_W'(1))
              phase <= PH_DONE;
            else
            begin
              byteCnt <= byteCnt + 1'b1;
              seqByteStart <= 1'b1;
              seqTxByte <= DUMMY_BYTE;
            end
          end
        PH_DONE:
        begin
          phase <= PH_IDLE;
          seqCsN <= CS_INACTIVE;
          sdInitRdy <= isInit;
          blockRdy <= !isInit;
        end
        default:
          phase <= PH_IDLE;
      endcase
    end
  end

endmodule

// File: src/spiBitTimer.sv
// SPI bit timer module: SCLK divider, bit counter, sample and shift strobes, byte-done pulse
module spiBitTimer
  import spiBusPkg::*;
#(
  parameter int CLK_DIV = 2
)
(
  input  logic clk,
  input  logic rst,
  input  logic byteGo,
  output logic sclk,
  output logic sampleStrobe,
  output logic shiftStrobe,
  output logic byteDone,
  output logic busy
);

  localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  logic [DIV_W-1:0] divCnt;
  bitCountT         bitCnt;
  // One SCLK half-period has elapsed
  logic             edgeTick;

  assign edgeTick     = busy && (divCnt == DIV_W'(CLK_DIV - 1));
  // Mode 0 samples on rising SCLK and shifts on falling SCLK
  assign sampleStrobe = edgeTick && !sclk;
  assign shiftStrobe  = edgeTick && sclk;
  // Counter wraps to zero on the 8th rising edge, so only the last falling edge sees zero
  assign byteDone     = shiftStrobe && (bitCnt == '0);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy   <= 1'b0;
      sclk   <= 1'b0;
      divCnt <= '0;
      bitCnt <= '0;
    end
    else if (!busy)
    begin
      busy   <= byteGo;
      divCnt <= '0;
      bitCnt <= '0;
    end
    else if (edgeTick)
    begin
      divCnt <= '0;
      sclk   <= !sclk;
      if (sampleStrobe)
        bitCnt <= bitCnt + 1'b1;
      if (byteDone)
        busy <= 1'b0;
    end
    else
      divCnt <= divCnt + 1'b1;
  end

endmodule

// File: src/spiBusPkg.sv
// SPI line-level package: byte and bit index types, transfer status and chip-select levels
package spiBusPkg;

  ////////////////////
  // Line-level widths
  ////////////////////

  // One byte on MOSI or MISO
  typedef logic [7:0] byteT;

  // Bit index within a byte that wraps after eight bits
  typedef logic [2:0] bitCountT;

  // Host-visible transfer status
  typedef logic transStsT;
  localparam transStsT TRANS_BUSY     = 1'b1;
  localparam transStsT TRANS_NOT_BUSY = 1'b0;

  // Chip select is active low on the card
  localparam logic CS_ACTIVE   = 1'b0;
  localparam logic CS_INACTIVE = 1'b1;

endpackage

// File: src/spiByteShifter.sv
// SPI byte shifter module: transmit source select, MSB-first shift out, receive capture and ready flag
module spiByteShifter
  import spiBusPkg::*;
#(
  parameter int CLK_DIV = 2
)
(
  input  logic clk,
  input  logic rst,
  input  logic txDataWen,
  input  byteT txData,
  input  logic seqByteStart,
  input  byteT seqTxByte,
  input  logic rxDataRdyClr,
  input  logic miso,
  output logic mosi,
  output logic sclk,
  output byteT rxData,
  output logic rxDataRdy,
  output logic byteDone
);

  byteT txShift;
  byteT rxShift;
  logic byteGo;
  logic busy;
  logic sampleStrobe;
  logic shiftStrobe;
  // New byte requested by either the host path or the sequencer
  logic loadByte;

  assign loadByte = (txDataWen || seqByteStart) && !busy;
  assign mosi     = txShift[7];

  spiBitTimer #(
    .CLK_DIV(CLK_DIV)
  ) i_bitTimer (
    .clk         (clk),
    .rst         (rst),
    .byteGo      (byteGo),
    .sclk        (sclk),
    .sampleStrobe(sampleStrobe),
    .shiftStrobe (shiftStrobe),
    .byteDone    (byteDone),
    .busy        (busy)
  );

  // Timer starts one cycle after the load
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      byteGo    <= 1'b0;
      rxDataRdy <= 1'b0;
    end
    else
    begin
      byteGo <= loadByte;
      if (byteDone)
        rxDataRdy <= 1'b1;
      else if (rxDataRdyClr || loadByte)
        rxDataRdy <= 1'b0;
    end
  end

  ////////////////////
  // Data path
  ////////////////////
  always_ff @(posedge clk)
  begin
    if (loadByte)
      txShift <= txDataWen ? txData : seqTxByte;
    else if (shiftStrobe)
      txShift <= {txShift[6:0], 1'b1};
    if (sampleStrobe)
      rxShift <= {rxShift[6:0], miso};
    if (byteDone)
      rxData <= rxShift;
  end

endmodule

// File: src/spiCtrl.sv
// SPI dispatcher FSM: starts direct, SD init or block accesses, owns chip select and busy status
module spiCtrl
  import spiBusPkg::*;
  import sdAccessPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      transStart,
  input  transTypeT transType,
  input  logic      rxDataRdy,
  input  logic      sdInitRdy,
  input  logic      blockRdy,
  input  logic      seqCsN,
  output logic      txDataWen,
  output logic      rxDataRdyClr,
  output logic      sdInitReq,
  output blockReqT  blockReq,
  output logic      spiCsN,
  output transStsT  transSts
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WAIT_REQ,
    ST_DIR_ACC,
    ST_WAIT_FIN1,
    ST_INIT,
    ST_WAIT_FIN2,
    ST_RW,
    ST_WAIT_FIN3
  } ctrlStateT;

  ctrlStateT state;
  ctrlStateT stateNext;
  logic      txDataWenNext;
  logic      rxDataRdyClrNext;
  logic      sdInitReqNext;
  blockReqT  blockReqNext;
  transStsT  transStsNext;
  // Chip select driven by this block for direct bytes
  logic      dirCsN;
  logic      dirCsNNext;

  // Sequencer owns chip select for the whole init or block access
  assign spiCsN = (state inside {ST_INIT, ST_WAIT_FIN2, ST_RW, ST_WAIT_FIN3}) ? seqCsN : dirCsN;

  ////////////////////
  // Next-state logic
  ////////////////////
  always_comb
  begin
    stateNext        = state;
    txDataWenNext    = txDataWen;
    rxDataRdyClrNext = rxDataRdyClr;
    sdInitReqNext    = sdInitReq;
    blockReqNext     = blockReq;
    transStsNext     = transSts;
    dirCsNNext       = dirCsN;
    case (state)
      ST_IDLE:
        stateNext = ST_WAIT_REQ;
      ST_WAIT_REQ:
      begin
        rxDataRdyClrNext = 1'b0;
        // Start is only looked at here, so a start while busy is dropped
        if (transStart)
        begin
          transStsNext = TRANS_BUSY;
          case (transType)
            DIRECT_ACCESS:
            begin
              stateNext     = ST_DIR_ACC;
              txDataWenNext = 1'b1;
              dirCsNNext    = CS_ACTIVE;
            end
            INIT_SD:
            begin
              stateNext     = ST_INIT;
              sdInitReqNext = 1'b1;
            end
            RW_READ_SD_BLOCK:
            begin
              stateNext    = ST_RW;
              blockReqNext = READ_SD_BLOCK;
            end
            RW_WRITE_SD_BLOCK:
            begin
              stateNext    = ST_RW;
              blockReqNext = WRITE_SD_BLOCK;
            end
            default:
              transStsNext = TRANS_NOT_BUSY;
          endcase
        end
      end
      // Request pulses drop after one cycle
      ST_DIR_ACC:
      begin
        txDataWenNext = 1'b0;
        stateNext     = ST_WAIT_FIN1;
      end
      ST_WAIT_FIN1:
        if (rxDataRdy)
        begin
          stateNext        = ST_WAIT_REQ;
          rxDataRdyClrNext = 1'b1;
          dirCsNNext       = CS_INACTIVE;
          transStsNext     = TRANS_NOT_BUSY;
        end
      ST_INIT:
      begin
        sdInitReqNext = 1'b0;
        stateNext     = ST_WAIT_FIN2;
      end
      ST_WAIT_FIN2:
        if (sdInitRdy)
        begin
          stateNext    = ST_WAIT_REQ;
          transStsNext = TRANS_NOT_BUSY;
        end
      ST_RW:
      begin
        blockReqNext = NO_BLOCK_REQ;
        stateNext    = ST_WAIT_FIN3;
      end
      ST_WAIT_FIN3:
        if (blockRdy)
        begin
          stateNext    = ST_WAIT_REQ;
          transStsNext = TRANS_NOT_BUSY;
        end
      default:
        stateNext = ST_IDLE;
    endcase
  end

  // Registered state and outputs
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state        <= ST_IDLE;
      txDataWen    <= 1'b0;
      rxDataRdyClr <= 1'b0;
      sdInitReq    <= 1'b0;
      blockReq     <= NO_BLOCK_REQ;
      transSts     <= TRANS_NOT_BUSY;
      dirCsN       <= CS_INACTIVE;
    end
    else
    begin
      state        <= stateNext;
      txDataWen    <= txDataWenNext;
      rxDataRdyClr <= rxDataRdyClrNext;
      sdInitReq    <= sdInitReqNext;
      blockReq     <= blockReqNext;
      transSts     <= transStsNext;
      dirCsN       <= dirCsNNext;
    end
  end

endmodule

// File: src/spiMaster.sv
// SPI master top module: dispatcher, byte shifter and SD sequencer wiring
module spiMaster
  import spiBusPkg::*;
  import sdAccessPkg::*;
#(
  parameter int CLK_DIV   = 2,
  parameter int BLOCK_LEN = 16
)
(
  input  logic      clk,
  input  logic      rst,
  input  transTypeT transType,
  input  logic      transStart,
  output transStsT  transSts,
  input  byteT      txData,
  output byteT      rxData,
  input  blockAddrT blockAddr,
  input  byteT      writeData,
  output logic      writeDataStrobe,
  output byteT      readData,
  output logic      readDataValid,
  output logic      spiCsN,
  output logic      sclk,
  output logic      mosi,
  input  logic      miso
);

  ////////////////////
  // Internal wiring
  ////////////////////
  logic     txDataWen;
  logic     rxDataRdy;
  logic     rxDataRdyClr;
  logic     sdInitReq;
  logic     sdInitRdy;
  blockReqT blockReq;
  logic     blockRdy;
  logic     seqCsN;
  logic     seqByteStart;
  byteT     seqTxByte;
  logic     byteDone;

  spiCtrl i_ctrl (
    .clk         (clk),
    .rst         (rst),
    .transStart  (transStart),
    .transType   (transType),
    .rxDataRdy   (rxDataRdy),
    .sdInitRdy   (sdInitRdy),
    .blockRdy    (blockRdy),
    .seqCsN      (seqCsN),
    .txDataWen   (txDataWen),
    .rxDataRdyClr(rxDataRdyClr),
    .sdInitReq   (sdInitReq),
    .blockReq    (blockReq),
    .spiCsN      (spiCsN),
    .transSts    (transSts)
  );

  // Shared by direct bytes and sequencer bytes
  spiByteShifter #(
    .CLK_DIV(CLK_DIV)
  ) i_shifter (
    .clk         (clk),
    .rst         (rst),
    .txDataWen   (txDataWen),
    .txData      (txData),
    .seqByteStart(seqByteStart),
    .seqTxByte   (seqTxByte),
    .rxDataRdyClr(rxDataRdyClr),
    .miso        (miso),
    .mosi        (mosi),
    .sclk        (sclk),
    .rxData      (rxData),
    .rxDataRdy   (rxDataRdy),
    .byteDone    (byteDone)
  );

  sdSequencer #(
    .BLOCK_LEN(BLOCK_LEN)
  ) i_sequencer (
    .clk            (clk),
    .rst            (rst),
    .sdInitReq      (sdInitReq),
    .blockReq       (blockReq),
    .blockAddr      (blockAddr),
    .writeData      (writeData),
    .byteDone       (byteDone),
    .rxData         (rxData),
    .seqByteStart   (seqByteStart),
    .seqTxByte      (seqTxByte),
    .seqCsN         (seqCsN),
    .sdInitRdy      (sdInitRdy),
    .blockRdy       (blockRdy),
    .writeDataStrobe(writeDataStrobe),
    .readData       (readData),
    .readDataValid  (readDataValid)
  );

endmodule

// File: verification/sdCardModel.sv
// SD card model: SPI mode 0 slave that logs MOSI bytes with chip select and drives LFSR MISO bytes
module sdCardModel
  import spiBusPkg::*;
(
  input  logic csN,
  input  logic sclk,
  input  logic mosi,
  output logic miso
);

  localparam logic [31:0] LFSR_SEED = 32'h5927;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  // One entry per byte clocked, in bus order
  byteT mosiLog[$];
  logic csLog[$];
  byteT misoLog[$];

  logic [31:0] lfsrState;
  byteT        rxByte;
  byteT        txByte;
  byteT        txShift;
  logic        csSeen;
  int          bitCnt;

  // Galois step as a right shift with the tap mask
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ LFSR_TAPS;
    return n;
  endfunction

  // One LFSR step per MISO bit
  task automatic nextMisoByte(output byteT b);
    for (int i = 0; i < 8; i++)
    begin
      b = {b[6:0], lfsrState[0]};
      lfsrState = lfsrNext(lfsrState);
    end
  endtask

  ////////////////////
  // Mode 0 slave
  ////////////////////
  initial
  begin
    lfsrState = LFSR_SEED;
    bitCnt    = 0;
    rxByte    = '0;
    csSeen    = 1'b1;
    nextMisoByte(txByte);
    txShift = txByte;
    miso    = txShift[7];
    forever
    begin
      @(sclk);
      // Rising edge samples MOSI
      if (sclk === 1'b1)
      begin
        rxByte = {rxByte[6:0], mosi};
        csSeen = csN;
        bitCnt++;
      end
      else if (sclk === 1'b0)
      begin
        // Eighth falling edge closes the byte
        if (bitCnt == 8)
        begin
          mosiLog.push_back(rxByte);
          csLog.push_back(csSeen);
          misoLog.push_back(txByte);
          bitCnt = 0;
          nextMisoByte(txByte);
          txShift = txByte;
          miso    = txShift[7];
        end
        // Reset edge with no bits seen leaves MISO alone
        else if (bitCnt != 0)
        begin
          txShift = {txShift[6:0], 1'b1};
          miso    = txShift[7];
        end
      end
    end
  end

endmodule

// File: verification/spiMasterTb.sv
// SPI master testbench: clock, reset, LFSR stimulus, reference byte lists, compare tasks, watchdog
module spiMasterTb
  import spiBusPkg::*;
  import sdAccessPkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int CLK_DIV      = 2;
  localparam int BLOCK_LEN    = 16;
  localparam int DIRECT_BYTES = 20;
  // Bytes clocked by each access
  localparam int INIT_BYTES   = 16;
  localparam int WRITE_BYTES  = 7 + BLOCK_LEN + 2;
  localparam int READ_BYTES   = 6 + BLOCK_LEN;
  localparam int TEST_BYTES   = DIRECT_BYTES + INIT_BYTES + WRITE_BYTES + READ_BYTES;
  localparam int WATCHDOG_TIME = TEST_BYTES * 16 * CLK_DIV * CLK_PERIOD * 2;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic      clk;
  logic      rst;
  transTypeT transType;
  logic      transStart;
  transStsT  transSts;
  byteT      txData;
  byteT      rxData;
  blockAddrT blockAddr;
  byteT      writeData;
  logic      writeDataStrobe;
  byteT      readData;
  logic      readDataValid;
  logic      spiCsN;
  logic      sclk;
  logic      mosi;
  logic      miso;

  logic [31:0] lfsrState;
  // Reference stream for the access under test
  byteT        expBytes[$];
  logic        expCs[$];
  byteT        blockBytes[$];
  byteT        readBytes[$];
  blockAddrT   writeAddr;
  blockAddrT   readAddr;

  spiMaster #(
    .CLK_DIV  (CLK_DIV),
    .BLOCK_LEN(BLOCK_LEN)
  ) i_dut (
    .clk            (clk),
    .rst            (rst),
    .transType      (transType),
    .transStart     (transStart),
    .transSts       (transSts),
    .txData         (txData),
    .rxData         (rxData),
    .blockAddr      (blockAddr),
    .writeData      (writeData),
    .writeDataStrobe(writeDataStrobe),
    .readData       (readData),
    .readDataValid  (readDataValid),
    .spiCsN         (spiCsN),
    .sclk           (sclk),
    .mosi           (mosi),
    .miso           (miso)
  );

  sdCardModel i_card (
    .csN (spiCsN),
    .sclk(sclk),
    .mosi(mosi),
    .miso(miso)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_TIME);
    failRun("Timeout: the accesses did not finish in the allowed time");
  end

  ////////////////////
  // Random source
  ////////////////////
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ LFSR_TAPS;
    return n;
  endfunction

  task automatic randomByte(output byteT b);
    for (int i = 0; i < 8; i++)
    begin
      b = {b[6:0], lfsrState[0]};
      lfsrState = lfsrNext(lfsrState);
    end
  endtask

  task automatic randomAddr(output blockAddrT a);
    byteT b;
    for (int i = 0; i < 4; i++)
    begin
      randomByte(b);
      a = {a[23:0], b};
    end
  endtask

  ////////////////////
  // Checks
  ////////////////////
  task automatic failRun(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic checkByte(input string name, input byteT got, input byteT exp);
    if (got !== exp)
      failRun($sformatf("ERR %s got %h expected %h", name, got, exp));
  endtask

  task automatic checkSts(input string name, input transStsT got, input transStsT exp);
    if (got !== exp)
      failRun($sformatf("ERR %s got %h expected %h", name, got, exp));
  endtask

  // Chip select and SCLK levels
  task automatic checkPin(input string name, input logic got, input logic exp);
    if (got !== exp)
      failRun($sformatf("ERR %s got %h expected %h", name, got, exp));
  endtask

  task automatic expectByte(input byteT b, input logic cs);
    expBytes.push_back(b);
    expCs.push_back(cs);
  endtask

  // Command argument goes out MSB first
  task automatic expectAddr(input blockAddrT a);
    expectByte(a[31:24], 1'b0);
    expectByte(a[23:16], 1'b0);
    expectByte(a[15:8], 1'b0);
    expectByte(a[7:0], 1'b0);
  endtask

  // Card log from base on must match the reference list exactly
  task automatic compareLog(input int base);
    if (i_card.mosiLog.size() != base + expBytes.size())
      failRun($sformatf("Card logged %0d bytes where %0d were expected",
                        i_card.mosiLog.size() - base, expBytes.size()));
    for (int i = 0; i < expBytes.size(); i++)
    begin
      checkByte("mosi", i_card.mosiLog[base + i], expBytes[i]);
      checkPin("spiCsN", i_card.csLog[base + i], expCs[i]);
    end
    expBytes.delete();
    expCs.delete();
  endtask

  ////////////////////
  // Host actions
  ////////////////////
  task automatic startTransfer(input transTypeT t);
    @(negedge clk);
    transType  = t;
    transStart = 1'b1;
    @(negedge clk);
    transStart = 1'b0;
    checkSts("transSts", transSts, TRANS_BUSY);
  endtask

  // Start strobe that a busy DUT must drop
  task automatic pulseIgnoredStart();
    @(negedge clk);
    transType  = DIRECT_ACCESS;
    txData     = 8'hA5;
    transStart = 1'b1;
    @(negedge clk);
    transStart = 1'b0;
  endtask

  task automatic waitIdle();
    while (transSts !== TRANS_NOT_BUSY)
      @(negedge clk);
    checkPin("spiCsN", spiCsN, 1'b1);
  endtask

  task automatic waitBytes(input int n);
    while (i_card.mosiLog.size() < n)
      @(negedge clk);
  endtask

  // Next host byte after each strobe
  task automatic feedWriteData();
    int idx;
    idx = 0;
    while (idx < BLOCK_LEN)
    begin
      @(negedge clk);
      if (writeDataStrobe)
      begin
        idx++;
        if (idx < BLOCK_LEN)
          writeData = blockBytes[idx];
      end
    end
  endtask

  task automatic collectReadData();
    while (readBytes.size() < BLOCK_LEN)
    begin
      @(negedge clk);
      if (readDataValid)
        readBytes.push_back(readData);
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////
  initial
  begin
    int   base;
    byteT b;
    rst        = 1'b1;
    transType  = DIRECT_ACCESS;
    transStart = 1'b0;
    txData     = '0;
    blockAddr  = '0;
    writeData  = '0;
    lfsrState  = 32'h5927;
    // Addresses first, so host bytes do not line up with card bytes
    randomAddr(writeAddr);
    randomAddr(readAddr);
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    checkPin("spiCsN", spiCsN, 1'b1);
    checkPin("sclk", sclk, 1'b0);
    checkSts("transSts", transSts, TRANS_NOT_BUSY);

    // Direct bytes with the MISO byte coming back on rxData
    for (int i = 0; i < DIRECT_BYTES; i++)
    begin
      randomByte(b);
      txData = b;
      base = i_card.mosiLog.size();
      startTransfer(DIRECT_ACCESS);
      waitIdle();
      expectByte(b, 1'b0);
      compareLog(base);
      checkByte("rxData", rxData, i_card.misoLog[base]);
    end

    // Init with a stray start during the dummy run
    base = i_card.mosiLog.size();
    startTransfer(INIT_SD);
    waitBytes(base + 4);
    pulseIgnoredStart();
    waitIdle();
    for (int i = 0; i < 10; i++)
      expectByte(8'hFF, 1'b1);
    expectByte(8'h40, 1'b0);
    expectAddr('0);
    expectByte(8'h95, 1'b0);
    compareLog(base);

    // Block write with a stray start during the address bytes
    for (int i = 0; i < BLOCK_LEN; i++)
    begin
      randomByte(b);
      blockBytes.push_back(b);
    end
    blockAddr = writeAddr;
    writeData = blockBytes[0];
    base = i_card.mosiLog.size();
    startTransfer(RW_WRITE_SD_BLOCK);
    fork
      feedWriteData();
      begin
        waitBytes(base + 3);
        pulseIgnoredStart();
        waitIdle();
      end
    join
    expectByte(8'h58, 1'b0);
    expectAddr(writeAddr);
    expectByte(8'hFF, 1'b0);
    expectByte(8'hFE, 1'b0);
    for (int i = 0; i < BLOCK_LEN; i++)
      expectByte(blockBytes[i], 1'b0);
    expectByte(8'hFF, 1'b0);
    expectByte(8'hFF, 1'b0);
    compareLog(base);

    // Block read where the fill bytes return the card's MISO bytes
    blockAddr = readAddr;
    base = i_card.mosiLog.size();
    startTransfer(RW_READ_SD_BLOCK);
    fork
      collectReadData();
      waitIdle();
    join
    expectByte(8'h51, 1'b0);
    expectAddr(readAddr);
    expectByte(8'hFF, 1'b0);
    for (int i = 0; i < BLOCK_LEN; i++)
      expectByte(8'hFF, 1'b0);
    compareLog(base);
    for (int i = 0; i < BLOCK_LEN; i++)
      checkByte("readData", readBytes[i], i_card.misoLog[base + 6 + i]);

    $display("RESULT: PASS");
    $finish;
  end

endmodule
